//--- verilog/fetchPkg.sv
`default_nettype none

package fetchPkg;

	//////////////////////////////
	// widths
	//////////////////////////////
	typedef logic [15:0] word_t;       // instruction word or word address
	typedef logic [2:0]  regIndex_t;   // r0..r7
	typedef logic [3:0]  instrClass_t; // decoded instruction class
	typedef logic [4:0]  opcode_t;     // top five bits of a word

	//////////////////////////////
	// instruction classes
	//////////////////////////////
	localparam instrClass_t CLASS_NOP      = 4'd0;
	localparam instrClass_t CLASS_ALU_IMM  = 4'd1; // addiu, addiu3, addsp, li, sltui
	localparam instrClass_t CLASS_ALU_REG  = 4'd2; // addu subu and or not neg cmp slt move
	localparam instrClass_t CLASS_SHIFT    = 4'd3; // sll, sra
	localparam instrClass_t CLASS_BRANCH   = 4'd4; // b, beqz, bnez, bteqz
	localparam instrClass_t CLASS_JUMP_REG = 4'd5; // jr
	localparam instrClass_t CLASS_LOAD     = 4'd6; // lw, lw_sp
	localparam instrClass_t CLASS_STORE    = 4'd7; // sw, sw_sp
	localparam instrClass_t CLASS_SPECIAL  = 4'd8; // mfih, mtih, mfpc, mtsp
	localparam instrClass_t CLASS_INVALID  = 4'd15;

	//////////////////////////////
	// major opcodes, bits 15..11
	//////////////////////////////
	localparam opcode_t OP_NOP    = 5'b00001;
	localparam opcode_t OP_B      = 5'b00010;
	localparam opcode_t OP_BEQZ   = 5'b00100;
	localparam opcode_t OP_BNEZ   = 5'b00101;
	localparam opcode_t OP_SHIFT  = 5'b00110; // sll / sra, split on bits 1..0
	localparam opcode_t OP_ADDIU3 = 5'b01000;
	localparam opcode_t OP_ADDIU  = 5'b01001;
	localparam opcode_t OP_SLTUI  = 5'b01011;
	localparam opcode_t OP_SPGRP  = 5'b01100; // bteqz / addsp / mtsp, split on bits 10..8
	localparam opcode_t OP_LI     = 5'b01101;
	localparam opcode_t OP_MOVE   = 5'b01111;
	localparam opcode_t OP_LW_SP  = 5'b10010;
	localparam opcode_t OP_LW     = 5'b10011;
	localparam opcode_t OP_SW_SP  = 5'b11010;
	localparam opcode_t OP_SW     = 5'b11011;
	localparam opcode_t OP_RRR    = 5'b11100; // addu / subu
	localparam opcode_t OP_RR     = 5'b11101; // two-register alu, jr, mfpc
	localparam opcode_t OP_IH     = 5'b11110; // mfih / mtih

	// the one legal nop word
	localparam word_t NOP_WORD = 16'h0800;

	//////////////////////////////
	// minor codes
	//////////////////////////////
	localparam logic [2:0] SUB_BTEQZ = 3'b000; // bits 10..8 in OP_SPGRP
	localparam logic [2:0] SUB_ADDSP = 3'b011;
	localparam logic [2:0] SUB_MTSP  = 3'b100;

	localparam logic [1:0] FUNC_ADDU = 2'b01;  // bits 1..0 in OP_RRR
	localparam logic [1:0] FUNC_SUBU = 2'b11;
	localparam logic [1:0] FUNC_SLL  = 2'b00;  // bits 1..0 in OP_SHIFT
	localparam logic [1:0] FUNC_SRA  = 2'b11;

	localparam logic [4:0] FUNC_JRPC = 5'b00000; // bits 4..0 in OP_RR
	localparam logic [4:0] FUNC_SLT  = 5'b00010;
	localparam logic [4:0] FUNC_CMP  = 5'b01010;
	localparam logic [4:0] FUNC_NEG  = 5'b01011;
	localparam logic [4:0] FUNC_AND  = 5'b01100;
	localparam logic [4:0] FUNC_OR   = 5'b01101;
	localparam logic [4:0] FUNC_NOT  = 5'b01111;
	localparam logic [2:0] SEL_JR    = 3'b000; // bits 7..5 under FUNC_JRPC
	localparam logic [2:0] SEL_MFPC  = 3'b010;

	localparam logic [7:0] IH_MFIH   = 8'h00;  // low byte in OP_IH
	localparam logic [7:0] IH_MTIH   = 8'h01;

endpackage

`default_nettype wire

//--- verilog/programCounter.sv
`timescale 1ns/10ps
`default_nettype none

module programCounter import fetchPkg::*;
#(
	parameter word_t resetVector = 16'h0000 // first fetch address after reset
)
(
	input  wire   clk,
	input  wire   reset,
	input  wire   run,            // fetch allowed
	input  wire   memConflict,    // shared memory busy with a data access
	input  wire   redirect,       // one-cycle strobe from the branch resolver
	input  word_t redirectTarget,
	output word_t fetchPc,        // address presented to the memory this cycle
	output logic  fetchEnable,
	output word_t wordPc,         // address of the word now on fetchWord
	output logic  wordValid
);

	// memory read happens whenever this is high, redirect or not
	assign fetchEnable = run && !memConflict;

	//////////////////////////////
	// fetch address
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			fetchPc   <= resetVector;
			wordValid <= 1'b0;
		end
		else if (redirect)
		begin
			// redirect wins over a stall, word read this edge is dropped
			fetchPc   <= redirectTarget;
			wordValid <= 1'b0;
		end
		else
		begin
			wordValid <= fetchEnable;   // one bubble per stalled cycle
			if (fetchEnable)
				fetchPc <= fetchPc + 16'd1; // word addressed, so step by one
		end
	end

	//////////////////////////////
	// address tag
	//////////////////////////////
	// follows the memory output register, so it loads on the same condition
	always_ff @(posedge clk)
	begin
		if (fetchEnable)
			wordPc <= fetchPc;
	end

	// branch unit only ever pulses redirect
	redirectIsStrobe: assert property (
		@(posedge clk) disable iff (reset)
		redirect |=> !redirect
	) else $error("redirect held high for two cycles");

endmodule

`default_nettype wire

//--- verilog/instructionMemory.sv
`timescale 1ns/10ps
`default_nettype none

module instructionMemory import fetchPkg::*;
#(
	parameter int memAddrBits = 6 // depth is 2**memAddrBits words
)
(
	input  wire                   clk,
	input  wire                   fetchEnable,
	input  word_t                 fetchPc,
	input  wire                   loadEnable,  // fill port, used while stopped
	input  wire [memAddrBits-1:0] loadAddress,
	input  word_t                 loadData,
	output word_t                 fetchWord
);

	localparam int memDepth = 1 << memAddrBits;

	word_t memPool [0:memDepth-1]; // program storage, no reset

	// upper pc bits are dropped, program wraps around the array
	wire [memAddrBits-1:0] readAddress = fetchPc[memAddrBits-1:0];

	//////////////////////////////
	// load port
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (loadEnable)
			memPool[loadAddress] <= loadData;
	end

	//////////////////////////////
	// synchronous read
	//////////////////////////////
	// output register holds its word across a stall
	always_ff @(posedge clk)
	begin
		if (fetchEnable)
			fetchWord <= memPool[readAddress];
	end

	// program is filled only while the fetch side is stopped
	noLoadDuringFetch: assert property (
		@(posedge clk)
		!(loadEnable && fetchEnable)
	) else $error("memory load while fetch is running");

endmodule

`default_nettype wire

//--- verilog/instructionDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instructionDecoder import fetchPkg::*;
(
	input  wire         clk,
	input  wire         reset,
	input  wire         redirect,     // flushes the word being decoded
	input  word_t       fetchWord,
	input  word_t       wordPc,
	input  wire         wordValid,
	output logic        decodedValid,
	output word_t       decodedPc,
	output instrClass_t instrClass,
	output regIndex_t   rx,
	output regIndex_t   ry,
	output regIndex_t   rz,
	output word_t       immediate,
	output word_t       branchTarget
);

	//////////////////////////////
	// field slices
	//////////////////////////////
	opcode_t   op;
	logic [2:0] subSel;   // bits 10..8 select within OP_SPGRP
	logic [2:0] midSel;   // bits 7..5 select jr or mfpc
	logic [4:0] func5;    // bits 4..0
	logic [1:0] func2;    // bits 1..0
	word_t     sext4;
	word_t     sext5;
	word_t     sext8;
	word_t     zext8;
	word_t     sext11;
	word_t     shiftAmount;

	assign op     = fetchWord[15:11];
	assign subSel = fetchWord[10:8];
	assign midSel = fetchWord[7:5];
	assign func5  = fetchWord[4:0];
	assign func2  = fetchWord[1:0];

	assign sext4  = {{12{fetchWord[3]}}, fetchWord[3:0]};  // addiu3
	assign sext5  = {{11{fetchWord[4]}}, fetchWord[4:0]};  // lw, sw
	assign sext8  = {{8{fetchWord[7]}}, fetchWord[7:0]};
	assign zext8  = {8'h00, fetchWord[7:0]};               // li, sltui
	assign sext11 = {{5{fetchWord[10]}}, fetchWord[10:0]}; // b
	// shift field of zero stands for eight
	assign shiftAmount = (fetchWord[4:2] == 3'b000) ? 16'd8 : {13'd0, fetchWord[4:2]};

	//////////////////////////////
	// class and immediate
	//////////////////////////////
	instrClass_t nextClass;
	word_t       nextImm;

	always_comb
	begin
		nextClass = CLASS_INVALID; // anything not matched below
		nextImm   = 16'h0000;
		case (op)
			OP_NOP:
				if (fetchWord == NOP_WORD)
					nextClass = CLASS_NOP;
			OP_B:
			begin
				nextClass = CLASS_BRANCH;
				nextImm   = sext11;
			end
			OP_BEQZ, OP_BNEZ:
			begin
				nextClass = CLASS_BRANCH;
				nextImm   = sext8;
			end
			OP_SHIFT:
				if (func2 == FUNC_SLL || func2 == FUNC_SRA)
				begin
					nextClass = CLASS_SHIFT;
					nextImm   = shiftAmount;
				end
			OP_ADDIU3:
				if (!fetchWord[4]) // bit 4 is fixed zero
				begin
					nextClass = CLASS_ALU_IMM;
					nextImm   = sext4;
				end
			OP_ADDIU:
			begin
				nextClass = CLASS_ALU_IMM;
				nextImm   = sext8;
			end
			OP_SLTUI, OP_LI:
			begin
				nextClass = CLASS_ALU_IMM;
				nextImm   = zext8;
			end
			OP_SPGRP:
				case (subSel)
					SUB_BTEQZ:
					begin
						nextClass = CLASS_BRANCH;
						nextImm   = sext8;
					end
					SUB_ADDSP:
					begin
						nextClass = CLASS_ALU_IMM;
						nextImm   = sext8;
					end
					SUB_MTSP:
						if (func5 == 5'b00000)
							nextClass = CLASS_SPECIAL;
					default: ;
				endcase
			OP_MOVE:
				if (func5 == 5'b00000)
					nextClass = CLASS_ALU_REG;
			OP_LW_SP:
			begin
				nextClass = CLASS_LOAD;
				nextImm   = sext8;
			end
			OP_LW:
			begin
				nextClass = CLASS_LOAD;
				nextImm   = sext5;
			end
			OP_SW_SP:
			begin
				nextClass = CLASS_STORE;
				nextImm   = sext8;
			end
			OP_SW:
			begin
				nextClass = CLASS_STORE;
				nextImm   = sext5;
			end
			OP_RRR:
				if (func2 == FUNC_ADDU || func2 == FUNC_SUBU)
					nextClass = CLASS_ALU_REG;
			OP_RR:
				case (func5)
					FUNC_JRPC:
						if (midSel == SEL_JR)
							nextClass = CLASS_JUMP_REG;
						else if (midSel == SEL_MFPC)
							nextClass = CLASS_SPECIAL;
					FUNC_SLT, FUNC_CMP, FUNC_NEG, FUNC_AND, FUNC_OR, FUNC_NOT:
						nextClass = CLASS_ALU_REG;
					default: ;
				endcase
			OP_IH:
				if (fetchWord[7:0] == IH_MFIH || fetchWord[7:0] == IH_MTIH)
					nextClass = CLASS_SPECIAL;
			default: ;
		endcase
	end

	//////////////////////////////
	// decode register
	//////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
			decodedValid <= 1'b0;
		else
			decodedValid <= wordValid && !redirect; // second word in flight dies here
	end

	always_ff @(posedge clk)
	begin
		decodedPc    <= wordPc;
		instrClass   <= nextClass;
		rx           <= fetchWord[10:8]; // fixed field positions for any class
		ry           <= fetchWord[7:5];
		rz           <= fetchWord[4:2];
		immediate    <= nextImm;
		branchTarget <= wordPc + 16'd1 + nextImm; // only meaningful for branches
	end

	// a valid word must come from a filled memory location
	wordKnownWhenValid: assert property (
		@(posedge clk) disable iff (reset)
		wordValid |-> !$isunknown(fetchWord)
	) else $error("unknown instruction word on a valid fetch");

endmodule

`default_nettype wire

//--- verilog/fetchDecodeTop.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecodeTop import fetchPkg::*;
#(
	parameter int    memAddrBits = 6,      // 64-word program store
	parameter word_t resetVector = 16'h0000
)
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   run,
	input  wire                   memConflict,
	input  wire                   redirect,
	input  word_t                 redirectTarget,
	input  wire                   loadEnable,
	input  wire [memAddrBits-1:0] loadAddress,
	input  word_t                 loadData,
	output logic                  decodedValid,
	output word_t                 decodedPc,
	output instrClass_t           instrClass,
	output regIndex_t             rx,
	output regIndex_t             ry,
	output regIndex_t             rz,
	output word_t                 immediate,
	output word_t                 branchTarget
);

	//////////////////////////////
	// fetch stage wires
	//////////////////////////////
	word_t fetchPc;     // pc unit -> memory
	logic  fetchEnable;
	word_t fetchWord;   // memory -> decoder
	word_t wordPc;      // tag beside fetchWord
	logic  wordValid;

	programCounter #(
		.resetVector(resetVector)
	) pcUnit (
		.clk(clk),
		.reset(reset),
		.run(run),
		.memConflict(memConflict),
		.redirect(redirect),
		.redirectTarget(redirectTarget),
		.fetchPc(fetchPc),
		.fetchEnable(fetchEnable),
		.wordPc(wordPc),
		.wordValid(wordValid)
	);

	instructionMemory #(
		.memAddrBits(memAddrBits)
	) instrMem (
		.clk(clk),
		.fetchEnable(fetchEnable),
		.fetchPc(fetchPc),
		.loadEnable(loadEnable),
		.loadAddress(loadAddress),
		.loadData(loadData),
		.fetchWord(fetchWord)
	);

	// decode stage, redirect also flushes here
	instructionDecoder decoder (
		.clk(clk),
		.reset(reset),
		.redirect(redirect),
		.fetchWord(fetchWord),
		.wordPc(wordPc),
		.wordValid(wordValid),
		.decodedValid(decodedValid),
		.decodedPc(decodedPc),
		.instrClass(instrClass),
		.rx(rx),
		.ry(ry),
		.rz(rz),
		.immediate(immediate),
		.branchTarget(branchTarget)
	);

endmodule

`default_nettype wire

//--- verif/fetchDecodeChecker.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecodeChecker import fetchPkg::*;
#(
	parameter int    memAddrBits = 6,
	parameter word_t resetVector = 16'h0000
)
(
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   run,
	input  wire                   memConflict,
	input  wire                   redirect,
	input  word_t                 redirectTarget,
	input  wire                   loadEnable,
	input  wire [memAddrBits-1:0] loadAddress,
	input  word_t                 loadData,
	input  wire                   decodedValid,
	input  word_t                 decodedPc,
	input  instrClass_t           instrClass,
	input  regIndex_t             rx,
	input  regIndex_t             ry,
	input  regIndex_t             rz,
	input  word_t                 immediate,
	input  word_t                 branchTarget
);

	localparam int memDepth = 1 << memAddrBits;

	// {fixed bits, free bits, class, immediate kind}
	// kind 0 none, 1 sext4, 2 sext5, 3 sext8, 4 zext8, 5 sext11, 6 shift
	localparam logic [39:0] listed [0:29] = '{
		{16'h4000, 16'h07EF, CLASS_ALU_IMM,  4'd1}, {16'h4800, 16'h07FF, CLASS_ALU_IMM,  4'd3},
		{16'h6300, 16'h00FF, CLASS_ALU_IMM,  4'd3}, {16'hE001, 16'h07FC, CLASS_ALU_REG,  4'd0},
		{16'hE80C, 16'h07E0, CLASS_ALU_REG,  4'd0}, {16'h1000, 16'h07FF, CLASS_BRANCH,   4'd5},
		{16'h2000, 16'h07FF, CLASS_BRANCH,   4'd3}, {16'h2800, 16'h07FF, CLASS_BRANCH,   4'd3},
		{16'h6000, 16'h00FF, CLASS_BRANCH,   4'd3}, {16'hE80A, 16'h07E0, CLASS_ALU_REG,  4'd0},
		{16'hE800, 16'h0700, CLASS_JUMP_REG, 4'd0}, {16'h6800, 16'h07FF, CLASS_ALU_IMM,  4'd4},
		{16'h9800, 16'h07FF, CLASS_LOAD,     4'd2}, {16'h9000, 16'h07FF, CLASS_LOAD,     4'd3},
		{16'hF000, 16'h0700, CLASS_SPECIAL,  4'd0}, {16'hE840, 16'h0700, CLASS_SPECIAL,  4'd0},
		{16'h7800, 16'h07E0, CLASS_ALU_REG,  4'd0}, {16'hF001, 16'h0700, CLASS_SPECIAL,  4'd0},
		{16'h6400, 16'h00E0, CLASS_SPECIAL,  4'd0}, {16'hE80B, 16'h07E0, CLASS_ALU_REG,  4'd0},
		{16'hE80F, 16'h07E0, CLASS_ALU_REG,  4'd0}, {16'h0800, 16'h0000, CLASS_NOP,      4'd0},
		{16'hE80D, 16'h07E0, CLASS_ALU_REG,  4'd0}, {16'h3000, 16'h07FC, CLASS_SHIFT,    4'd6},
		{16'hE802, 16'h07E0, CLASS_ALU_REG,  4'd0}, {16'h5800, 16'h07FF, CLASS_ALU_IMM,  4'd4},
		{16'h3003, 16'h07FC, CLASS_SHIFT,    4'd6}, {16'hE003, 16'h07FC, CLASS_ALU_REG,  4'd0},
		{16'hD800, 16'h07FF, CLASS_STORE,    4'd2}, {16'hD000, 16'h07FF, CLASS_STORE,    4'd3}
	};

	string testName   = "none"; // set by the testbench before each test
	int    errorCount = 0;
	int    checkCount = 0;     // valid decodes compared

	word_t       memCopy [0:memDepth-1];
	word_t       modelPc;
	logic        stage1Valid = 1'b0; // word on the memory output
	logic        stage2Valid = 1'b0; // word on the decoder output
	word_t       stage1Pc;
	word_t       stage1Word;
	word_t       stage2Pc;
	word_t       stage2Word;
	instrClass_t expClass;
	word_t       expImm;

	// reference decode by one template match per listed instruction
	function automatic void modelDecode(input word_t w, output instrClass_t cls, output word_t imm);
		int k;
		cls = CLASS_INVALID;
		imm = 16'h0000;
		for (k = 0; k < 30; k++)
		begin
			if ((w & ~listed[5'(k)][23:8]) == listed[5'(k)][39:24])
			begin
				cls = listed[5'(k)][7:4];
				case (listed[5'(k)][3:0])
					4'd1: imm = {{12{w[3]}}, w[3:0]};
					4'd2: imm = {{11{w[4]}}, w[4:0]};
					4'd3: imm = {{8{w[7]}}, w[7:0]};
					4'd4: imm = {8'h00, w[7:0]};
					4'd5: imm = {{5{w[10]}}, w[10:0]};
					4'd6: imm = (w[4:2] == 3'd0) ? 16'd8 : {13'd0, w[4:2]}; // 0 -> 8
					default: imm = 16'h0000;
				endcase
			end
		end
	endfunction

	task automatic compareValue(input string field, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			errorCount++;
			$display("Error %s: %s at pc %h expected %h actual %h",
				testName, field, stage2Pc, expected, actual);
		end
	endtask

	//////////////////////////////
	// model of the fetch stream
	//////////////////////////////
	always @(posedge clk)
	begin
		if (loadEnable)
			memCopy[loadAddress] = loadData; // mirror of the fill port
		if (reset)
		begin
			modelPc     = resetVector;
			stage1Valid = 1'b0;
			stage2Valid = 1'b0;
		end
		else
		begin
			stage2Valid = stage1Valid && !redirect; // second word flushed too
			stage2Pc    = stage1Pc;
			stage2Word  = stage1Word;
			if (run && !memConflict)
			begin
				stage1Word = memCopy[modelPc[memAddrBits-1:0]]; // pc wraps the array
				stage1Pc   = modelPc;
			end
			if (redirect)
			begin
				modelPc     = redirectTarget;
				stage1Valid = 1'b0;
			end
			else
			begin
				stage1Valid = run && !memConflict; // a stall is a bubble
				if (run && !memConflict)
					modelPc = modelPc + 16'd1;
			end
		end
	end

	//////////////////////////////
	// compare away from the edge
	//////////////////////////////
	always @(negedge clk)
	begin
		if (!reset)
		begin
			compareValue("decodedValid", {15'd0, stage2Valid}, {15'd0, decodedValid});
			if (stage2Valid && decodedValid === 1'b1)
			begin
				modelDecode(stage2Word, expClass, expImm);
				checkCount++;
				compareValue("decodedPc", stage2Pc, decodedPc);
				compareValue("instrClass", {12'd0, expClass}, {12'd0, instrClass});
				compareValue("rx", {13'd0, stage2Word[10:8]}, {13'd0, rx});
				compareValue("ry", {13'd0, stage2Word[7:5]}, {13'd0, ry});
				compareValue("rz", {13'd0, stage2Word[4:2]}, {13'd0, rz});
				compareValue("immediate", expImm, immediate);
				compareValue("branchTarget", stage2Pc + 16'd1 + expImm, branchTarget);
			end
		end
	end

endmodule

`default_nettype wire

//--- verif/fetchDecodeTb.sv
`timescale 1ns/10ps
`default_nettype none

module fetchDecodeTb import fetchPkg::*;
#(
	parameter int    memAddrBits = 6,
	parameter word_t resetVector = 16'h0000
)
();

	localparam int memDepth    = 1 << memAddrBits;
	localparam int testCount   = 6;
	localparam int drainCycles = 4; // lets the last two words leave the pipe
	localparam int runLength [0:testCount-1] = '{150, 200, 200, 80, 80, 300};

	// {fixed bits, free bits} for every listed instruction, same order as the checker
	localparam logic [31:0] encodings [0:29] = '{
		32'h4000_07EF, 32'h4800_07FF, 32'h6300_00FF, 32'hE001_07FC, 32'hE80C_07E0,
		32'h1000_07FF, 32'h2000_07FF, 32'h2800_07FF, 32'h6000_00FF, 32'hE80A_07E0,
		32'hE800_0700, 32'h6800_07FF, 32'h9800_07FF, 32'h9000_07FF, 32'hF000_0700,
		32'hE840_0700, 32'h7800_07E0, 32'hF001_0700, 32'h6400_00E0, 32'hE80B_07E0,
		32'hE80F_07E0, 32'h0800_0000, 32'hE80D_07E0, 32'h3000_07FC, 32'hE802_07E0,
		32'h5800_07FF, 32'h3003_07FC, 32'hE003_07FC, 32'hD800_07FF, 32'hD000_07FF
	};

	function automatic int totalRunLength();
		int i;
		int total;
		total = 0;
		for (i = 0; i < testCount; i++)
			total += runLength[3'(i)];
		return total;
	endfunction

	// fill, one reset cycle and drain per test, plus the first reset and slack
	localparam int watchdogCycles =
		4 + totalRunLength() + testCount * (memDepth + 2 + drainCycles) + 100;

	logic                   clk = 1'b0;
	logic                   reset;
	logic                   run;
	logic                   memConflict;
	logic                   redirect;
	word_t                  redirectTarget;
	logic                   loadEnable;
	logic [memAddrBits-1:0] loadAddress;
	word_t                  loadData;
	logic                   decodedValid;
	word_t                  decodedPc;
	instrClass_t            instrClass;
	regIndex_t              rx;
	regIndex_t              ry;
	regIndex_t              rz;
	word_t                  immediate;
	word_t                  branchTarget;

	logic [31:0] lfsrState   = 32'h1462;
	int          failedTests = 0;

	fetchDecodeTop #(
		.memAddrBits(memAddrBits),
		.resetVector(resetVector)
	) DUT (
		.clk(clk), .reset(reset), .run(run), .memConflict(memConflict),
		.redirect(redirect), .redirectTarget(redirectTarget),
		.loadEnable(loadEnable), .loadAddress(loadAddress), .loadData(loadData),
		.decodedValid(decodedValid), .decodedPc(decodedPc), .instrClass(instrClass),
		.rx(rx), .ry(ry), .rz(rz), .immediate(immediate), .branchTarget(branchTarget)
	);

	// passive, only looks at the DUT ports
	fetchDecodeChecker #(
		.memAddrBits(memAddrBits),
		.resetVector(resetVector)
	) monitor (
		.clk(clk), .reset(reset), .run(run), .memConflict(memConflict),
		.redirect(redirect), .redirectTarget(redirectTarget),
		.loadEnable(loadEnable), .loadAddress(loadAddress), .loadData(loadData),
		.decodedValid(decodedValid), .decodedPc(decodedPc), .instrClass(instrClass),
		.rx(rx), .ry(ry), .rz(rz), .immediate(immediate), .branchTarget(branchTarget)
	);

	initial
	begin
		forever #10 clk = ~clk; // 20 ns period
	end

	//////////////////////////////
	// random source
	//////////////////////////////
	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]}; // taps 32 22 2 1
	endfunction

	function automatic word_t takeBits(input int count);
		int    i;
		word_t value;
		value = 16'h0000;
		for (i = 0; i < count; i++)
		begin
			lfsrState = nextLfsr(lfsrState); // one step per bit
			value     = {value[14:0], lfsrState[0]};
		end
		return value;
	endfunction

	// kind 0 random, 1 every listed instruction, 2 branches between random words
	function automatic word_t fillWord(input int kind, input int address);
		word_t       rnd;
		logic [31:0] entry;
		rnd   = takeBits(16);
		entry = encodings[5'(address % 30)];
		if (kind == 1 && address >= 30)
			rnd = rnd & 16'hFFE3; // second pass: shift field 0, meaning 8
		if (kind == 2)
			entry = encodings[5'd5 + 5'(takeBits(2))]; // b, beqz, bnez, bteqz
		if (kind == 0 || (kind == 2 && address % 2 == 1))
			return rnd;
		return entry[31:16] | (rnd & entry[15:0]);
	endfunction

	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	//////////////////////////////
	// one test: fill, restart, run
	//////////////////////////////
	task automatic runTest(input string name, input int fillKind, input bit stallOn,
		input bit redirectOn, input int cycles);
		int a;
		int errorsBefore;
		int checksBefore;
		int errors;
		int checks;
		errorsBefore     = monitor.errorCount;
		checksBefore     = monitor.checkCount;
		monitor.testName = name;
		for (a = 0; a < memDepth; a++)
		begin
			nextCycle();
			loadEnable  = 1'b1;
			loadAddress = a[memAddrBits-1:0];
			loadData    = fillWord(fillKind, a);
		end
		nextCycle();
		loadEnable = 1'b0;
		reset      = 1'b1; // fetch restarts at resetVector
		nextCycle();
		reset = 1'b0;
		run   = 1'b1;
		for (a = 0; a < cycles; a++)
		begin
			memConflict    = stallOn && (takeBits(2) == 16'd0);
			redirect       = redirectOn && !redirect && (takeBits(3) == 16'd0); // strobe only
			redirectTarget = takeBits(16);
			nextCycle();
		end
		run         = 1'b0;
		memConflict = 1'b0;
		redirect    = 1'b0;
		repeat (drainCycles) nextCycle();
		errors = monitor.errorCount - errorsBefore;
		checks = monitor.checkCount - checksBefore;
		if (errors != 0 || checks == 0)
			failedTests++;
		if (checks == 0)
			$display("test %s: no valid decode came out of the DUT", name);
		$display("test %s: %0d decodes checked, %0d errors", name, checks, errors);
	endtask

	initial
	begin
		reset          = 1'b1;
		run            = 1'b0;
		memConflict    = 1'b0;
		redirect       = 1'b0;
		redirectTarget = 16'h0000;
		loadEnable     = 1'b0;
		loadAddress    = '0;
		loadData       = 16'h0000;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;
		runTest("sequential",    0, 1'b0, 1'b0, runLength[0]);
		runTest("stall",         0, 1'b1, 1'b0, runLength[1]);
		runTest("redirect",      0, 1'b0, 1'b1, runLength[2]);
		runTest("decodeFields",  1, 1'b0, 1'b0, runLength[3]);
		runTest("branchTargets", 2, 1'b0, 1'b0, runLength[4]);
		runTest("mixed",         0, 1'b1, 1'b1, runLength[5]);
		$display("%0d tests, %0d failed, %0d decodes checked, %0d errors",
			testCount, failedTests, monitor.checkCount, monitor.errorCount);
		if (failedTests == 0 && monitor.errorCount == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (watchdogCycles) @(posedge clk);
		$display("run timed out after %0d clock cycles", watchdogCycles);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
verilog/fetchPkg.sv
verilog/programCounter.sv
verilog/instructionMemory.sv
verilog/instructionDecoder.sv
verilog/fetchDecodeTop.sv
verif/fetchDecodeChecker.sv
verif/fetchDecodeTb.sv

//--- Makefile
# build and run the fetch/decode testbench with Verilator

VERILATOR ?= verilator
TOP       ?= fetchDecodeTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0
PASS_LINE ?= TEST OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the simulation with Verilator and run it"
	@echo "         (fails unless the run prints the pass line)"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_LINE)"

clean:
	rm -rf $(OBJ_DIR)
